//--- bench/icache_properties.sv
module icache_properties (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    r_req,
    input logic                    r_rdy,
    input logic [31:0]             r_addr,
    input logic                    r_data_ready,
    input logic                    data_valid,
    input icache_pkg::ctrl_state_e state
);

    // address phase holds until the memory takes it
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        r_req && !r_rdy |=> r_req && $stable(r_addr))
        else $error("r_req dropped or r_addr changed before r_rdy");

    a_ready_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
        r_data_ready |-> state == icache_pkg::REFILL)
        else $error("r_data_ready high outside REFILL");

    a_no_resp_in_miss: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid |-> !(state inside {icache_pkg::MISS, icache_pkg::REFILL}))
        else $error("data_valid during MISS or REFILL");

endmodule

bind icache icache_properties props_inst (
    .clk(clk), .rst_n(rst_n), .r_req(r_req), .r_rdy(r_rdy), .r_addr(r_addr),
    .r_data_ready(r_data_ready), .data_valid(data_valid), .state(ctrl_inst.state)
);

//--- bench/icache_tb.sv
module icache_tb;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] cookie;
        logic        hit;
        logic [31:0] edge_no;   // acceptance edge
    } expect_t;

    logic clk, rst_n, valid, req_ready, data_valid, r_req, r_rdy, r_data_ready;
    logic ret_valid, ret_last;
    logic [31:0] pc_in, cookie_in, pc_out, cookie_out, r_addr, r_data_axi;
    logic [63:0] r_data_cpu;
    logic [31:0] rng = 32'd9360;
    logic [31:0] mem_rng = 32'd9360;   // memory stalls
    int cyc = 0, mismatches = 0, other_errors = 0;
    int misses = 0, refills = 0, responses = 0, accepted = 0;
    bit timed_out = 0;
    expect_t pending[$];
    logic [19:0] m_tag [64][4];
    bit m_val [64][4];
    int m_age [64][4];   // 0 youngest
    logic last_hit = 1'b1;
    logic [31:0] last_line;

    icache icache_inst (.*);

    initial begin
        clk = 0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ 32'h5A5A0000;
    endfunction

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) $display("RESULT: PASS");
        else $display("RESULT: FAIL");
        $finish;
    endtask

    function automatic void timeout_error(input string what);
        other_errors++;
        timed_out = 1;
        $display("timeout at %0t: %s", $time, what);
    endfunction

    // reference lru cache that returns hit and updates tags and ages
    function automatic bit model_access(input logic [31:0] pc);
        int idx, way, a;
        idx = pc[11:6];
        way = -1;
        for (int w = 0; w < 4; w++) if (m_val[idx][w] && m_tag[idx][w] == pc[31:12]) way = w;
        model_access = (way >= 0);
        if (way < 0) begin
            for (int w = 3; w >= 0; w--) if (m_age[idx][w] == 3) way = w;
            for (int w = 3; w >= 0; w--) if (!m_val[idx][w]) way = w;
            m_tag[idx][way] = pc[31:12];
            m_val[idx][way] = 1;
        end
        a = m_age[idx][way];
        for (int w = 0; w < 4; w++) begin
            if (w == way) m_age[idx][w] = 0;
            else if (m_age[idx][w] < a) m_age[idx][w]++;
        end
    endfunction

    // called on a falling edge and returns on the falling edge after acceptance
    task automatic fetch(input logic [31:0] pc, output logic hit);
        int n;
        expect_t e;
        n = 0;
        valid = 1;
        pc_in = pc;
        rng = xorshift(rng);
        cookie_in = rng;
        // a hit leaves the cache ready for the next fetch at once
        assert (!last_hit || req_ready) else begin
            mismatches++;
            $display("mismatch at %0t: req_ready low after a hit", $time);
        end
        while (!req_ready && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            timeout_error("request never accepted");
        end else begin
            hit = model_access(pc);
            if (!hit) misses++;
            last_hit = hit;
            last_line = {pc[31:6], 6'b0};
            e = '{pc, cookie_in, hit, cyc + 1};
            pending.push_back(e);
            accepted++;
            @(negedge clk);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        valid = 0;
        while (!timed_out && pending.size() != 0 && n < 3000) begin
            @(negedge clk);
            n++;
        end
        if (!timed_out && pending.size() != 0) begin
            timeout_error("responses missing");
        end
    endtask

    always @(negedge clk) begin : check_resp
        expect_t e;
        logic [31:0] a;
        if (rst_n && data_valid) begin
            if (pending.size() == 0) begin
                other_errors++;
                $display("response without a request at %0t", $time);
            end else begin
                e = pending.pop_front();
                a = {e.pc[31:3], 3'b0};   // 8-byte aligned
                responses++;
                assert (r_data_cpu == {mem_word(a + 4), mem_word(a)}) else begin
                    mismatches++;
                    $display("mismatch at %0t: data %h for pc %h", $time, r_data_cpu, e.pc);
                end
                assert (pc_out == e.pc && cookie_out == e.cookie) else begin
                    mismatches++;
                    $display("mismatch at %0t: pc %h cookie %h", $time, pc_out, cookie_out);
                end
                // the cpu samples the pulse on the next rising edge
                assert (!e.hit || cyc + 1 == e.edge_no + 2) else begin
                    mismatches++;
                    $display("mismatch at %0t: hit latency for pc %h", $time, e.pc);
                end
            end
        end
    end

    // memory side with random address and beat stalls
    initial begin
        int d, n;
        logic [31:0] a;
        forever begin
            @(negedge clk);
            if (r_req) begin
                refills++;
                a = r_addr;
                assert (!last_hit && a == last_line && refills == misses) else begin
                    mismatches++;
                    $display("mismatch at %0t: unexpected r_req for %h", $time, a);
                end
                mem_rng = xorshift(mem_rng);
                d = mem_rng % 4;
                repeat (d) @(negedge clk);
                r_rdy = 1;
                @(negedge clk);
                r_rdy = 0;
                for (int i = 0; i < 16; i++) begin
                    mem_rng = xorshift(mem_rng);
                    if (mem_rng % 4 == 0) begin
                        ret_valid = 0;
                        @(negedge clk);
                    end
                    ret_valid = 1;
                    ret_last = (i == 15);
                    r_data_axi = mem_word(a + 4 * i);
                    n = 0;
                    while (!r_data_ready && n < 100) begin
                        @(negedge clk);
                        n++;
                    end
                    if (!r_data_ready) begin
                        timeout_error("r_data_ready stuck low");
                        break;
                    end
                    @(negedge clk);
                end
                ret_valid = 0;
                ret_last = 0;
            end
        end
    end

    initial begin
        int seq_t [11] = '{0, 1, 2, 3, 0, 4, 0, 2, 3, 4, 1};
        bit seq_h [11] = '{0, 0, 0, 0, 1, 0, 1, 1, 1, 1, 0};
        logic h;
        logic [31:0] r;
        valid = 0;
        pc_in = 0;
        cookie_in = 0;
        r_rdy = 0;
        ret_valid = 0;
        ret_last = 0;
        r_data_axi = 0;
        rst_n = 0;
        for (int s = 0; s < 64; s++) begin
            for (int w = 0; w < 4; w++) begin
                m_val[s][w] = 0;
                m_age[s][w] = 3 - w;   // way 0 oldest
            end
        end
        repeat (8) begin
            @(negedge clk);
            assert (!r_req && !data_valid) else begin
                other_errors++;
                $display("r_req or data_valid active in reset at %0t", $time);
            end
        end
        rst_n = 1;
        // five tags in set 5 so the way holding tag 1 is evicted
        for (int i = 0; i < 11 && !timed_out; i++) begin
            fetch({20'h100 + 20'(seq_t[i]), 6'd5, 6'(4 * i)}, h);
            assert (timed_out || h == seq_h[i]) else begin
                other_errors++;
                $display("model lru prediction wrong at step %0d", i);
            end
        end
        drain();
        for (int k = 0; k < 300 && !timed_out; k++) begin
            rng = xorshift(rng);
            r = rng;
            fetch({20'h200 + 20'(r[10:8] % 5), r[4] ? 6'd9 : 6'd40, r[15:12], 2'b0}, h);
            if (r[20:19] == 0) begin
                valid = 0;
                repeat (r[23:22]) @(negedge clk);
            end
        end
        drain();
        assert (responses == accepted && refills == misses) else begin
            other_errors++;
            $display("%0d responses for %0d requests, %0d refills for %0d misses",
                     responses, accepted, refills, misses);
        end
        finish_run();
    end

endmodule

//--- hw/icache.sv
`include "icache_cfg.svh"

module icache (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          valid,
    input  logic [31:0]                   pc_in,
    input  logic [`ICACHE_COOKIE_W-1:0]   cookie_in,
    output logic                          req_ready,
    output logic                          data_valid,
    output logic [63:0]                   r_data_cpu,
    output logic [31:0]                   pc_out,
    output logic [`ICACHE_COOKIE_W-1:0]   cookie_out,
    output logic                          r_req,
    output logic [31:0]                   r_addr,
    input  logic                          r_rdy,
    output logic                          r_data_ready,
    input  logic                          ret_valid,
    input  logic                          ret_last,
    input  logic [31:0]                   r_data_axi
);

    icache_pkg::icache_req_t     req_in, req_buf;
    icache_pkg::icache_resp_t    resp;
    refill_bus_pkg::refill_req_t refill_req;
    refill_bus_pkg::line_t       fill_line;
    refill_bus_pkg::line_t [`ICACHE_WAYS-1:0] set_lines;
    logic [`ICACHE_WAYS-1:0] tag_we, data_we, touch_way, hit_way, victim_way;
    logic hit, fill_done, lru_touch, resp_load, resp_from_fill;

    assign req_in.pc     = pc_in;
    assign req_in.cookie = cookie_in;

    assign r_data_cpu = resp.data;
    assign pc_out     = resp.pc;
    assign cookie_out = resp.cookie;

    icache_refill refill_inst (
        .clk(clk), .rst_n(rst_n), .refill_req(refill_req),
        .r_req(r_req), .r_addr(r_addr), .r_rdy(r_rdy),
        .r_data_ready(r_data_ready), .ret_valid(ret_valid), .ret_last(ret_last),
        .r_data_axi(r_data_axi), .fill_done(fill_done), .fill_line(fill_line)
    );

    icache_tag_store tag_store_inst (
        .clk(clk), .rst_n(rst_n), .rd_pc(pc_in), .wr_pc(req_buf.pc),
        .tag_we(tag_we), .lru_touch(lru_touch), .touch_way(touch_way),
        .hit_way(hit_way), .hit(hit), .victim_way(victim_way)
    );

    icache_data_store data_store_inst (
        .clk(clk), .rd_pc(pc_in), .wr_pc(req_buf.pc), .data_we(data_we),
        .wr_line(fill_line), .set_lines(set_lines)
    );

    icache_ctrl ctrl_inst (
        .clk(clk), .rst_n(rst_n), .valid(valid), .req_in(req_in),
        .req_ready(req_ready), .hit(hit), .hit_way(hit_way),
        .victim_way(victim_way), .fill_done(fill_done), .req_buf(req_buf),
        .refill_req(refill_req), .tag_we(tag_we), .data_we(data_we),
        .lru_touch(lru_touch), .touch_way(touch_way), .resp_load(resp_load),
        .resp_from_fill(resp_from_fill)
    );

    icache_resp resp_inst (
        .clk(clk), .rst_n(rst_n), .set_lines(set_lines), .hit_way(hit_way),
        .fill_line(fill_line), .req_buf(req_buf), .resp_load(resp_load),
        .resp_from_fill(resp_from_fill), .data_valid(data_valid), .resp(resp)
    );

endmodule

//--- hw/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry
`define ICACHE_WAYS 4
`define ICACHE_SETS 64
`define ICACHE_LINE_WORDS 16

// opaque tag carried with every fetch
`define ICACHE_COOKIE_W 32

// address split, 32-bit pc = tag | index | offset
`define ICACHE_OFFSET_W 6
`define ICACHE_INDEX_W 6
`define ICACHE_TAG_W 20

`endif

//--- hw/icache_ctrl.sv
`include "icache_cfg.svh"

module icache_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        valid,
    input  icache_pkg::icache_req_t     req_in,
    output logic                        req_ready,
    input  logic                        hit,
    input  logic [`ICACHE_WAYS-1:0]     hit_way,
    input  logic [`ICACHE_WAYS-1:0]     victim_way,
    input  logic                        fill_done,
    output icache_pkg::icache_req_t     req_buf,
    output refill_bus_pkg::refill_req_t refill_req,
    output logic [`ICACHE_WAYS-1:0]     tag_we,
    output logic [`ICACHE_WAYS-1:0]     data_we,
    output logic                        lru_touch,
    output logic [`ICACHE_WAYS-1:0]     touch_way,
    output logic                        resp_load,
    output logic                        resp_from_fill
);

    icache_pkg::ctrl_state_e state, state_nxt;
    logic [`ICACHE_WAYS-1:0] victim_buf;
    logic lookup_hit, lookup_miss, in_replace, accept;

    assign lookup_hit  = (state == icache_pkg::LOOKUP) && hit;
    assign lookup_miss = (state == icache_pkg::LOOKUP) && !hit;
    assign in_replace  = (state == icache_pkg::REPLACE);

    assign req_ready = (state == icache_pkg::IDLE) || lookup_hit;  // hits pipeline
    assign accept    = valid && req_ready;

    always_comb begin
        state_nxt = state;
        unique case (state)
            icache_pkg::IDLE: begin
                if (valid) begin
                    state_nxt = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                if (!hit) begin
                    state_nxt = icache_pkg::MISS;
                end else if (!valid) begin
                    state_nxt = icache_pkg::IDLE;   // else next fetch in lookup
                end
            end
            icache_pkg::MISS:    state_nxt = icache_pkg::REFILL;
            icache_pkg::REFILL: begin
                if (fill_done) begin
                    state_nxt = icache_pkg::REPLACE;
                end
            end
            icache_pkg::REPLACE: state_nxt = icache_pkg::IDLE;
            default:             state_nxt = icache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= icache_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_buf <= req_in;
        end
        if (lookup_miss) begin
            victim_buf <= victim_way;   // ages may move before replace
        end
    end

    // r_req rises as the fsm enters MISS
    assign refill_req.start = lookup_miss;
    assign refill_req.addr  = {req_buf.pc[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

    assign tag_we  = in_replace ? victim_buf : '0;
    assign data_we = in_replace ? victim_buf : '0;

    assign lru_touch = lookup_hit || in_replace;
    assign touch_way = in_replace ? victim_buf : hit_way;

    assign resp_load      = lookup_hit || in_replace;
    assign resp_from_fill = in_replace;

endmodule

//--- hw/icache_data_store.sv
`include "icache_cfg.svh"

module icache_data_store (
    input  logic                                       clk,
    input  logic [31:0]                                rd_pc,
    input  logic [31:0]                                wr_pc,
    input  logic [`ICACHE_WAYS-1:0]                    data_we,
    input  refill_bus_pkg::line_t                      wr_line,
    output refill_bus_pkg::line_t [`ICACHE_WAYS-1:0]   set_lines
);

    localparam int SETS = `ICACHE_SETS;

    logic [`ICACHE_INDEX_W-1:0] rd_idx, wr_idx;

    assign rd_idx = rd_pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign wr_idx = wr_pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        refill_bus_pkg::line_t way_mem [SETS];
        refill_bus_pkg::line_t rd_q;

        always_ff @(posedge clk) begin
            if (data_we[w]) begin
                way_mem[wr_idx] <= wr_line;   // whole line at once
            end
            rd_q <= way_mem[rd_idx];
        end

        assign set_lines[w] = rd_q;
    end

endmodule

//--- hw/icache_pkg.sv
`include "icache_cfg.svh"

package icache_pkg;

    // one fetch from the cpu
    typedef struct packed {
        logic [31:0]                   pc;
        logic [`ICACHE_COOKIE_W-1:0]   cookie;
    } icache_req_t;

    // what goes back to the cpu with data_valid
    typedef struct packed {
        logic [63:0]                   data;   // two instructions
        logic [31:0]                   pc;
        logic [`ICACHE_COOKIE_W-1:0]   cookie;
    } icache_resp_t;

    typedef enum logic [2:0] {
        IDLE,       // waiting for a fetch
        LOOKUP,     // tags and data out of the stores
        MISS,       // line read issued to memory
        REFILL,     // collecting beats
        REPLACE     // line and tag written, response sent
    } ctrl_state_e;

endpackage

//--- hw/icache_refill.sv
`include "icache_cfg.svh"

module icache_refill (
    input  logic                        clk,
    input  logic                        rst_n,
    input  refill_bus_pkg::refill_req_t refill_req,
    output logic                        r_req,
    output logic [31:0]                 r_addr,
    input  logic                        r_rdy,
    output logic                        r_data_ready,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  logic [31:0]                 r_data_axi,
    output logic                        fill_done,
    output refill_bus_pkg::line_t       fill_line
);

    refill_bus_pkg::beat_idx_t beat_cnt;
    logic                      beat_take;

    assign beat_take = r_data_ready && ret_valid;
    assign fill_done = beat_take && ret_last;   // same edge as the last beat

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_req        <= 1'b0;
            r_data_ready <= 1'b0;
            beat_cnt     <= '0;
        end else begin
            if (refill_req.start) begin
                r_req <= 1'b1;
            end else if (r_req && r_rdy) begin
                r_req        <= 1'b0;   // address phase done
                r_data_ready <= 1'b1;
                beat_cnt     <= '0;
            end
            if (beat_take) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (ret_last) begin
                    r_data_ready <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_req.start) begin
            r_addr <= refill_req.addr;  // held until r_rdy
        end
        if (beat_take) begin
            fill_line[beat_cnt*32 +: 32] <= r_data_axi;
        end
    end

endmodule

//--- hw/icache_resp.sv
`include "icache_cfg.svh"

module icache_resp (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  refill_bus_pkg::line_t [`ICACHE_WAYS-1:0]   set_lines,
    input  logic [`ICACHE_WAYS-1:0]                    hit_way,
    input  refill_bus_pkg::line_t                      fill_line,
    input  icache_pkg::icache_req_t                    req_buf,
    input  logic                                       resp_load,
    input  logic                                       resp_from_fill,
    output logic                                       data_valid,
    output icache_pkg::icache_resp_t                   resp
);

    localparam int WORD_IDX_W = `ICACHE_OFFSET_W - 3;

    refill_bus_pkg::line_t  sel_line;
    logic [WORD_IDX_W-1:0]  word_idx;

    // hit_way is one-hot, or-ing the masked lines is the mux
    always_comb begin
        sel_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_way[w]) begin
                sel_line = sel_line | set_lines[w];
            end
        end
        if (resp_from_fill) begin
            sel_line = fill_line;
        end
    end

    assign word_idx = req_buf.pc[`ICACHE_OFFSET_W-1:3];   // 8-byte slot

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= resp_load;   // single pulse
        end
    end

    always_ff @(posedge clk) begin
        if (resp_load) begin
            resp.data   <= sel_line[word_idx*64 +: 64];
            resp.pc     <= req_buf.pc;
            resp.cookie <= req_buf.cookie;
        end
    end

endmodule

//--- hw/icache_tag_store.sv
`include "icache_cfg.svh"

module icache_tag_store (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             rd_pc,
    input  logic [31:0]             wr_pc,
    input  logic [`ICACHE_WAYS-1:0] tag_we,
    input  logic                    lru_touch,
    input  logic [`ICACHE_WAYS-1:0] touch_way,
    output logic [`ICACHE_WAYS-1:0] hit_way,
    output logic                    hit,
    output logic [`ICACHE_WAYS-1:0] victim_way
);

    localparam int WAYS  = `ICACHE_WAYS;
    localparam int SETS  = `ICACHE_SETS;
    localparam int TAG_W = `ICACHE_TAG_W;
    localparam int AGE_W = $clog2(WAYS);
    localparam int TAG_LSB = `ICACHE_OFFSET_W + `ICACHE_INDEX_W;

    logic [TAG_W-1:0] tag_mem   [WAYS][SETS];
    logic [SETS-1:0]  valid_bits [WAYS];
    logic [AGE_W-1:0] age       [SETS][WAYS];   // 0 = youngest
    logic [TAG_W-1:0] tag_q     [WAYS];
    logic [WAYS-1:0]  valid_q;
    logic [`ICACHE_INDEX_W-1:0] rd_idx, wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic [AGE_W-1:0] touched_age;

    assign rd_idx = rd_pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign wr_idx = wr_pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign wr_tag = wr_pc[TAG_LSB +: TAG_W];

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][wr_idx] <= wr_tag;
            end
            tag_q[w]   <= tag_mem[w][rd_idx];
            valid_q[w] <= valid_bits[w][rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_bits[w] <= '0;
            end
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (tag_we[w]) begin
                    valid_bits[w][wr_idx] <= 1'b1;
                end
            end
        end
    end

    // compared against the buffered pc, stores were read a cycle earlier
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = valid_q[w] && (tag_q[w] == wr_tag);
        end
    end
    assign hit = |hit_way;

    always_comb begin
        touched_age = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (touch_way[w]) begin
                touched_age = age[wr_idx][w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    age[s][w] <= AGE_W'(WAYS - 1 - w);  // way 0 oldest
                end
            end
        end else if (lru_touch) begin
            for (int w = 0; w < WAYS; w++) begin
                if (touch_way[w]) begin
                    age[wr_idx][w] <= '0;
                end else if (age[wr_idx][w] < touched_age) begin
                    age[wr_idx][w] <= age[wr_idx][w] + 1'b1;
                end
            end
        end
    end

    // free way first, lowest number wins; otherwise the oldest
    always_comb begin
        victim_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (age[wr_idx][w] == AGE_W'(WAYS - 1)) begin
                victim_way = WAYS'(1) << w;
            end
        end
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid_bits[w][wr_idx]) begin
                victim_way = WAYS'(1) << w;
            end
        end
    end

endmodule

//--- hw/refill_bus_pkg.sv
`include "icache_cfg.svh"

package refill_bus_pkg;

    // full cache line, beat 0 in the low 32 bits
    typedef logic [`ICACHE_LINE_WORDS*32-1:0] line_t;

    typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0] beat_idx_t;

    // line read request from the controller
    typedef struct packed {
        logic [31:0] addr;     // line aligned
        logic        start;    // one-cycle strobe
    } refill_req_t;

endpackage

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module icache_tb -o icache_sim
./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

//--- src.f
+incdir+hw
hw/icache_pkg.sv
hw/refill_bus_pkg.sv
hw/icache_refill.sv
hw/icache_tag_store.sv
hw/icache_data_store.sv
hw/icache_ctrl.sv
hw/icache_resp.sv
hw/icache.sv
bench/icache_properties.sv
bench/icache_tb.sv
